// File: Makefile
# Verilator build and run for the sliding-window unit

VERILATOR ?= verilator
TOP       ?= swu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
+incdir+include
hdl/swu_stream_pkg.sv
hdl/swu_geom_pkg.sv
hdl/swu_write_ctrl.sv
hdl/swu_window_seq.sv
hdl/swu_line_buffer.sv
hdl/swu_out_stage.sv
hdl/swu_top.sv
tb/swu_tb.sv

// File: hdl/swu_geom_pkg.sv
`include "swu_consts.svh"

package swu_geom_pkg;

   // input row, also counts completed rows so it must reach IFM_H
   typedef logic [$clog2(`SWU_IFM_H + 1)-1:0] in_row_t;

   // output pixel position
   typedef logic [$clog2(`SWU_OFM_H + 1)-1:0] out_row_t;
   typedef logic [$clog2(`SWU_OFM_W + 1)-1:0] out_col_t;

   // kernel row or column
   typedef logic [$clog2(`SWU_KERNEL + 1)-1:0] kidx_t;

   // word within one pixel
   typedef logic [$clog2(`SWU_EFF_CH + 1)-1:0] chan_t;

   // line buffer address and row slot
   typedef logic [$clog2(`SWU_BUF_WORDS)-1:0] buf_addr_t;
   typedef logic [$clog2(`SWU_KERNEL + 1)-1:0] slot_t;

endpackage

// File: hdl/swu_line_buffer.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_line_buffer #(
   parameter int DEPTH = `SWU_BUF_WORDS
) (
   input  logic                    clk,
   input  logic                    wr_en_i,
   input  swu_geom_pkg::buf_addr_t wr_addr_i,
   input  swu_stream_pkg::word_t   wr_data_i,
   input  logic                    rd_en_i,
   input  swu_geom_pkg::buf_addr_t rd_addr_i,
   output swu_stream_pkg::word_t   rd_data_o,
   output logic                    rd_valid_o
);

   swu_stream_pkg::word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read port, data and valid line up
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   always_ff @(posedge clk) begin
      rd_valid_o <= rd_en_i;
   end

   // writer and reader always sit in different rows of the window
   assert property (@(posedge clk)
      (wr_en_i && rd_en_i) |-> (wr_addr_i != rd_addr_i))
      else $error("read and write collide at address %0d", wr_addr_i);

endmodule

// File: hdl/swu_out_stage.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_out_stage (
   input  logic                  clk,
   input  logic                  resetn,
   input  logic                  rd_valid_i,
   input  swu_stream_pkg::word_t rd_data_i,
   output logic                  space_o,
   output swu_stream_pkg::word_t out_data_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i
);

   swu_stream_pkg::word_t q_mem [2];
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            count;
   logic                  push;
   logic                  pop;

   assign push = rd_valid_i;
   assign pop  = out_valid_o && out_ready_i;

   assign out_valid_o = (count != 2'd0);
   assign out_data_o  = q_mem[rd_ptr];

   // a read in flight already owns one entry
   assign space_o = ({1'b0, count} + {2'b00, rd_valid_i}) < 3'd2;

   //////////////////////////////////////////////////
   // queue storage
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (push) begin
         q_mem[wr_ptr] <= rd_data_i;
      end
   end

   //////////////////////////////////////////////////
   // pointers and fill level
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
      end
   end

   // space was checked a cycle before the word arrives
   assert property (@(posedge clk) disable iff (!resetn)
      rd_valid_i |-> (count < 2'd2))
      else $error("read word arrived at a full output queue");

endmodule

// File: hdl/swu_stream_pkg.sv
`include "swu_consts.svh"

package swu_stream_pkg;

   // one channel element
   typedef logic [`SWU_ELEM_BITS-1:0] elem_t;

   // SIMD elements side by side, element 0 in the low bits
   typedef elem_t [`SWU_SIMD-1:0] word_t;

endpackage

// File: hdl/swu_top.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_top (
   input  logic                  clk,
   input  logic                  resetn,
   input  swu_stream_pkg::word_t in_data_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output swu_stream_pkg::word_t out_data_o,
   output logic                  out_valid_o,
   input  logic                  out_ready_i
);

   logic                    wr_en;
   swu_geom_pkg::buf_addr_t wr_addr;
   swu_geom_pkg::in_row_t   rows_done;
   swu_geom_pkg::in_row_t   base_row;
   logic                    frame_done;
   logic                    rd_en;
   swu_geom_pkg::buf_addr_t rd_addr;
   swu_stream_pkg::word_t   rd_data;
   logic                    rd_valid;
   logic                    space;

   //////////////////////////////////////////////////
   // write side
   //////////////////////////////////////////////////

   swu_write_ctrl swu_write_ctrl_inst (
      .clk          (clk),
      .resetn       (resetn),
      .in_valid_i   (in_valid_i),
      .in_ready_o   (in_ready_o),
      .base_row_i   (base_row),
      .frame_done_i (frame_done),
      .wr_en_o      (wr_en),
      .wr_addr_o    (wr_addr),
      .rows_done_o  (rows_done)
   );

   swu_line_buffer #(
      .DEPTH (`SWU_BUF_WORDS)
   ) swu_line_buffer_inst (
      .clk        (clk),
      .wr_en_i    (wr_en),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (in_data_i),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .rd_data_o  (rd_data),
      .rd_valid_o (rd_valid)
   );

   //////////////////////////////////////////////////
   // read side
   //////////////////////////////////////////////////

   swu_window_seq swu_window_seq_inst (
      .clk          (clk),
      .resetn       (resetn),
      .rows_done_i  (rows_done),
      .space_i      (space),
      .rd_en_o      (rd_en),
      .rd_addr_o    (rd_addr),
      .base_row_o   (base_row),
      .frame_done_o (frame_done)
   );

   swu_out_stage swu_out_stage_inst (
      .clk         (clk),
      .resetn      (resetn),
      .rd_valid_i  (rd_valid),
      .rd_data_i   (rd_data),
      .space_o     (space),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// File: hdl/swu_window_seq.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_window_seq (
   input  logic                    clk,
   input  logic                    resetn,
   input  swu_geom_pkg::in_row_t   rows_done_i,
   input  logic                    space_i,
   output logic                    rd_en_o,
   output swu_geom_pkg::buf_addr_t rd_addr_o,
   output swu_geom_pkg::in_row_t   base_row_o,
   output logic                    frame_done_o
);

   swu_geom_pkg::chan_t    ch;
   swu_geom_pkg::kidx_t    kw;
   swu_geom_pkg::kidx_t    kh;
   swu_geom_pkg::out_col_t ox;
   swu_geom_pkg::out_row_t oy;
   swu_geom_pkg::slot_t    base_slot;
   swu_geom_pkg::slot_t    rd_slot;
   swu_geom_pkg::slot_t    base_slot_nxt;
   swu_geom_pkg::slot_t    rd_slot_inc;
   swu_geom_pkg::in_row_t  need_row;
   logic                   last_ch;
   logic                   last_kw;
   logic                   last_kh;
   logic                   last_ox;
   logic                   last_oy;
   int unsigned            addr_full;

   //////////////////////////////////////////////////
   // row availability
   //////////////////////////////////////////////////

   assign base_row_o = swu_geom_pkg::in_row_t'(oy * `SWU_STRIDE);
   assign need_row   = swu_geom_pkg::in_row_t'(base_row_o + kh);

   assign rd_en_o = space_i && (need_row < rows_done_i);

   assign last_ch = (ch == `SWU_EFF_CH - 1);
   assign last_kw = (kw == `SWU_KERNEL - 1);
   assign last_kh = (kh == `SWU_KERNEL - 1);
   assign last_ox = (ox == `SWU_OFM_W - 1);
   assign last_oy = (oy == `SWU_OFM_H - 1);

   assign frame_done_o = rd_en_o && last_ch && last_kw && last_kh && last_ox && last_oy;

   //////////////////////////////////////////////////
   // read address
   //////////////////////////////////////////////////

   assign addr_full = rd_slot * `SWU_ROW_WORDS
                    + (ox * `SWU_STRIDE + kw) * `SWU_EFF_CH + ch;
   assign rd_addr_o = swu_geom_pkg::buf_addr_t'(addr_full);

   assign rd_slot_inc = (rd_slot == `SWU_KERNEL - 1) ? '0 : rd_slot + 1'b1;

   // slot of the first window row once the output row advances by stride
   always_comb begin
      int unsigned nxt;
      nxt = base_slot + (`SWU_STRIDE % `SWU_KERNEL);
      if (nxt >= `SWU_KERNEL) begin
         nxt = nxt - `SWU_KERNEL;
      end
      base_slot_nxt = swu_geom_pkg::slot_t'(nxt);
   end

   //////////////////////////////////////////////////
   // window loop, channel word fastest
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch        <= '0;
         kw        <= '0;
         kh        <= '0;
         ox        <= '0;
         oy        <= '0;
         base_slot <= '0;
         rd_slot   <= '0;
      end else if (rd_en_o) begin
         if (!last_ch) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!last_kw) begin
               kw <= kw + 1'b1;
            end else begin
               kw <= '0;
               if (!last_kh) begin
                  kh      <= kh + 1'b1;
                  rd_slot <= rd_slot_inc;
               end else begin
                  kh <= '0;
                  if (!last_ox) begin
                     // next window starts again at the top row
                     ox      <= ox + 1'b1;
                     rd_slot <= base_slot;
                  end else begin
                     ox <= '0;
                     if (!last_oy) begin
                        oy        <= oy + 1'b1;
                        base_slot <= base_slot_nxt;
                        rd_slot   <= base_slot_nxt;
                     end else begin
                        // frame end, writer restarts at slot 0 as well
                        oy        <= '0;
                        base_slot <= '0;
                        rd_slot   <= '0;
                     end
                  end
               end
            end
         end
      end
   end

   assert property (@(posedge clk) disable iff (!resetn)
      rd_en_o |-> (addr_full < `SWU_BUF_WORDS))
      else $error("read address %0d beyond line buffer", addr_full);

endmodule

// File: hdl/swu_write_ctrl.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_write_ctrl (
   input  logic                    clk,
   input  logic                    resetn,
   input  logic                    in_valid_i,
   output logic                    in_ready_o,
   input  swu_geom_pkg::in_row_t   base_row_i,
   input  logic                    frame_done_i,
   output logic                    wr_en_o,
   output swu_geom_pkg::buf_addr_t wr_addr_o,
   output swu_geom_pkg::in_row_t   rows_done_o
);

   localparam int COL_BITS = $clog2(`SWU_IFM_W + 1);

   swu_geom_pkg::chan_t   ch;
   logic [COL_BITS-1:0]   col;
   swu_geom_pkg::in_row_t row;
   swu_geom_pkg::slot_t   slot;
   logic                  last_ch;
   logic                  last_col;
   int unsigned           row_limit;

   //////////////////////////////////////////////////
   // acceptance
   //////////////////////////////////////////////////

   // the window only needs rows base_row .. base_row+K-1 resident
   assign row_limit  = int'(base_row_i) + `SWU_KERNEL;
   assign in_ready_o = (row < `SWU_IFM_H) && (row < row_limit);
   assign wr_en_o    = in_valid_i && in_ready_o;

   // row being written equals the number of rows already complete
   assign rows_done_o = row;

   assign last_ch  = (ch == `SWU_EFF_CH - 1);
   assign last_col = (col == `SWU_IFM_W - 1);

   // slot picks the buffer row, col and ch the word inside it
   assign wr_addr_o = swu_geom_pkg::buf_addr_t'(slot * `SWU_ROW_WORDS
                                                + col * `SWU_EFF_CH + ch);

   //////////////////////////////////////////////////
   // position counters
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn || frame_done_i) begin
         ch   <= '0;
         col  <= '0;
         row  <= '0;
         slot <= '0;
      end else if (wr_en_o) begin
         if (!last_ch) begin
            ch <= ch + 1'b1;
         end else begin
            ch <= '0;
            if (!last_col) begin
               col <= col + 1'b1;
            end else begin
               col <= '0;
               row <= row + 1'b1;
               // wrap at kernel rows
               if (slot == `SWU_KERNEL - 1) begin
                  slot <= '0;
               end else begin
                  slot <= slot + 1'b1;
               end
            end
         end
      end
   end

   // rows still needed by the sequencer must never be overwritten
   assert property (@(posedge clk) disable iff (!resetn)
      int'(row) <= int'(base_row_i) + `SWU_KERNEL)
      else $error("writer at row %0d ran past base row %0d", row, base_row_i);

endmodule

// File: include/swu_consts.svh
`ifndef SWU_CONSTS_SVH
`define SWU_CONSTS_SVH

//////////////////////////////////////////////////
// stream word layout
//////////////////////////////////////////////////

`define SWU_SIMD        4
`define SWU_ELEM_BITS   4
`define SWU_WORD_BITS   (`SWU_SIMD * `SWU_ELEM_BITS)

//////////////////////////////////////////////////
// feature map and kernel geometry
//////////////////////////////////////////////////

`define SWU_IFM_CH      8
// words per pixel
`define SWU_EFF_CH      (`SWU_IFM_CH / `SWU_SIMD)
`define SWU_IFM_W       6
`define SWU_IFM_H       5
`define SWU_KERNEL      3
`define SWU_STRIDE      1

`define SWU_OFM_W       (((`SWU_IFM_W - `SWU_KERNEL) / `SWU_STRIDE) + 1)
`define SWU_OFM_H       (((`SWU_IFM_H - `SWU_KERNEL) / `SWU_STRIDE) + 1)

// line buffer holds kernel rows of one input row each
`define SWU_ROW_WORDS   (`SWU_IFM_W * `SWU_EFF_CH)
`define SWU_BUF_WORDS   (`SWU_KERNEL * `SWU_ROW_WORDS)

`endif

// File: tb/swu_tb.sv
`timescale 1ns/1ps
`include "swu_consts.svh"

module swu_tb;

   localparam int FRAMES        = 3;
   localparam int IN_PER_FRAME  = `SWU_IFM_H * `SWU_ROW_WORDS;
   localparam int OUT_PER_FRAME = `SWU_OFM_H * `SWU_OFM_W * `SWU_KERNEL * `SWU_KERNEL
                                  * `SWU_EFF_CH;
   localparam int IN_TOTAL      = FRAMES * IN_PER_FRAME;
   localparam int OUT_TOTAL     = FRAMES * OUT_PER_FRAME;
   localparam int CYCLE_LIMIT   = 20 * (IN_TOTAL + OUT_TOTAL);
   localparam int STALL_CYCLES  = 100;
   localparam int DRAIN_CYCLES  = 50;

   logic                  clk = 1'b0;
   logic                  resetn;
   swu_stream_pkg::word_t in_data_i;
   logic                  in_valid_i;
   logic                  in_ready_o;
   swu_stream_pkg::word_t out_data_o;
   logic                  out_valid_o;
   logic                  out_ready_i;

   // every accepted input word, all frames in arrival order
   swu_stream_pkg::word_t in_hist [IN_TOTAL];
   int                    in_sent = 0;
   int                    out_got = 0;
   int                    cycles = 0;
   int                    value_errors = 0;
   int                    other_errors = 0;
   logic                  in_fire = 1'b0;
   logic                  idle_checked = 1'b0;
   logic                  held_valid = 1'b0;
   swu_stream_pkg::word_t held_data;
   int                    stall_left = 0;
   logic                  stall_done = 1'b0;
   logic                  saw_ready_drop = 1'b0;

   swu_top swu_top_inst (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #20 clk = ~clk;

   //////////////////////////////////////////////////
   // reference window model
   //////////////////////////////////////////////////

   // input index of output word n; order is oy, ox, kh, kw, channel word
   function automatic int window_source_index(input int n);
      int r;
      int c;
      int kw;
      int kh;
      int ox;
      int oy;
      r  = n % OUT_PER_FRAME;
      c  = r % `SWU_EFF_CH;
      r  = r / `SWU_EFF_CH;
      kw = r % `SWU_KERNEL;
      r  = r / `SWU_KERNEL;
      kh = r % `SWU_KERNEL;
      r  = r / `SWU_KERNEL;
      ox = r % `SWU_OFM_W;
      oy = r / `SWU_OFM_W;
      return (n / OUT_PER_FRAME) * IN_PER_FRAME
           + ((oy * `SWU_STRIDE + kh) * `SWU_IFM_W + ox * `SWU_STRIDE + kw) * `SWU_EFF_CH + c;
   endfunction

   task automatic check_idle_outputs(input string when_txt);
      assert (out_valid_o == 1'b0) else begin
         $display("Fail out_valid_o %s: got %h expected 0", when_txt, out_valid_o);
         value_errors++;
      end
      assert (in_ready_o == 1'b1) else begin
         $display("Fail in_ready_o %s: got %h expected 1", when_txt, in_ready_o);
         value_errors++;
      end
   endtask

   //////////////////////////////////////////////////
   // monitor, samples on the falling edge
   //////////////////////////////////////////////////

   always @(negedge clk) begin : monitor
      int idx;
      cycles++;
      if (!resetn) begin
         check_idle_outputs("during reset");
      end else begin
         if (!idle_checked) begin
            check_idle_outputs("after reset");
            idle_checked = 1'b1;
         end
         // a stalled word must stay put until taken
         if (held_valid) begin
            assert (out_valid_o) else begin
               $display("Fail out_valid_o under back-pressure: got %h expected 1",
                        out_valid_o);
               value_errors++;
            end
            assert (out_data_o == held_data) else begin
               $display("Fail out_data_o under back-pressure: got %h expected %h",
                        out_data_o, held_data);
               value_errors++;
            end
         end
         if (stall_left > 0 && !in_ready_o) begin
            saw_ready_drop = 1'b1;
         end
         in_fire = in_valid_i && in_ready_o && (in_sent < IN_TOTAL);
         if (in_fire) begin
            in_hist[in_sent] = in_data_i;
            in_sent++;
         end
         if (out_valid_o && out_ready_i) begin
            assert (out_got < OUT_TOTAL) else begin
               $display("output word taken beyond the expected %0d words", OUT_TOTAL);
               other_errors++;
            end
            if (out_got < OUT_TOTAL) begin
               idx = window_source_index(out_got);
               assert (idx < in_sent) else begin
                  $display("output word %0d came before input word %0d was accepted",
                           out_got, idx);
                  other_errors++;
               end
               if (idx < in_sent) begin
                  assert (out_data_o == in_hist[idx]) else begin
                     $display("Fail out_data_o word %0d: got %h expected %h",
                              out_got, out_data_o, in_hist[idx]);
                     value_errors++;
                  end
               end
            end
            out_got++;
         end
         held_valid = out_valid_o && !out_ready_i;
         held_data  = out_data_o;
      end
   end

   //////////////////////////////////////////////////
   // stimulus, driven on the rising edge
   //////////////////////////////////////////////////

   always @(posedge clk) begin : driver
      logic [31:0] rnd;
      if (resetn) begin
         if (in_fire || !in_valid_i) begin
            rnd = $urandom;
            if (in_sent < IN_TOTAL && (rnd % 100) < 70) begin
               rnd = $urandom;
               in_valid_i <= 1'b1;
               in_data_i  <= rnd[`SWU_WORD_BITS-1:0];
            end else begin
               in_valid_i <= 1'b0;
            end
         end
         // one long output stall early in frame 2
         if (stall_left > 0) begin
            stall_left--;
            out_ready_i <= 1'b0;
            if (stall_left == 0) begin
               assert (saw_ready_drop) else begin
                  $display("in_ready_o never dropped while the output was stalled");
                  other_errors++;
               end
            end
         end else if (!stall_done && out_got >= OUT_PER_FRAME + 5) begin
            stall_done = 1'b1;
            stall_left = STALL_CYCLES;
            out_ready_i <= 1'b0;
         end else begin
            rnd = $urandom;
            out_ready_i <= ((rnd % 100) < 70);
         end
      end
   end

   initial begin : main
      resetn      = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      void'($urandom(32'h26ee55c1));
      repeat (16) @(posedge clk);
      resetn <= 1'b1;
      while (out_got < OUT_TOTAL && cycles < CYCLE_LIMIT) begin
         @(posedge clk);
      end
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles with %0d of %0d output words",
                  cycles, out_got, OUT_TOTAL);
         other_errors++;
      end else begin
         repeat (DRAIN_CYCLES) @(posedge clk);
      end
      assert (in_sent == IN_TOTAL) else begin
         $display("only %0d of %0d input words were accepted", in_sent, IN_TOTAL);
         other_errors++;
      end
      assert (out_got == OUT_TOTAL) else begin
         $display("%0d output words taken where %0d were expected", out_got, OUT_TOTAL);
         other_errors++;
      end
      $display("errors: %0d value, %0d other, %0d total",
               value_errors, other_errors, value_errors + other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
